// File: design/wbc_pkg.sv
/*
 * Sizes and message formats shared by the writeback and commit stage.
 * The design modules and the testbench take their types from this package.
 */
`default_nettype none

package wbc_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------

  // Execute pipes feeding the stage
  localparam int num_pipes = 2;

  // Pipe index width, at least one bit
  localparam int pipe_bits = (num_pipes > 1) ? $clog2(num_pipes) : 1;

  // Datapath widths
  localparam int addr_bits = 32;
  localparam int data_bits = 32;
  localparam int seq_bits  = 8;

  // Reorder buffer, indexed by low sequence bits
  localparam int rob_depth    = 16;
  localparam int rob_idx_bits = 4;

  // Architectural registers
  localparam int reg_addr_bits = 5;
  localparam int num_regs      = 2 ** reg_addr_bits;

  // --------------------------------------------------
  // Messages
  // --------------------------------------------------

  // Result from an execute pipe, 78 bits
  typedef struct packed {
    logic [addr_bits-1:0]     pc;
    logic [seq_bits-1:0]      seq_num;
    logic [reg_addr_bits-1:0] waddr;
    logic [data_bits-1:0]     wdata;
    logic                     wen;
  } x_w_msg_t;

  // Completion broadcast, no pc, 46 bits
  typedef struct packed {
    logic [seq_bits-1:0]      seq_num;
    logic [reg_addr_bits-1:0] waddr;
    logic [data_bits-1:0]     wdata;
    logic                     wen;
  } complete_msg_t;

  // Commit broadcast
  // Same layout as the execute result
  typedef struct packed {
    logic [addr_bits-1:0]     pc;
    logic [seq_bits-1:0]      seq_num;
    logic [reg_addr_bits-1:0] waddr;
    logic [data_bits-1:0]     wdata;
    logic                     wen;
  } commit_msg_t;

endpackage

`default_nettype wire

// File: design/writeback_select.sv
/*
 * Round-robin acceptance of execute results, one per cycle.
 * The winner is registered onto the completion outputs the next cycle,
 * with its pc on a side output for the reorder buffer.
 */
`timescale 1ns/1ns
`default_nettype none

module writeback_select (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  wbc_pkg::x_w_msg_t                    x_w_msg [wbc_pkg::num_pipes],
  input  logic [wbc_pkg::num_pipes-1:0]        x_w_val,
  output logic [wbc_pkg::num_pipes-1:0]        x_w_rdy,
  output logic                                 complete_val,
  output wbc_pkg::complete_msg_t               complete_msg,
  output logic [wbc_pkg::addr_bits-1:0]        complete_pc
);

  import wbc_pkg::*;

  // --------------------------------------------------
  // Arbitration
  // --------------------------------------------------

  // Pipe with first priority this cycle
  logic [pipe_bits-1:0] rr_ptr;

  // Winner of this cycle
  logic                 grant_found;
  logic [pipe_bits-1:0] grant_idx;
  logic [pipe_bits-1:0] next_ptr;

  // Message of the winning pipe
  x_w_msg_t             sel_msg;

  // Scan from the pointer, wrapping around
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int k = 0; k < num_pipes; k++) begin
      int                   cand_sum;
      logic [pipe_bits-1:0] cand;
      cand_sum = int'(rr_ptr) + k;
      if (cand_sum >= num_pipes) begin
        cand_sum = cand_sum - num_pipes;
      end
      cand = pipe_bits'(cand_sum);
      if (!grant_found && x_w_val[cand]) begin
        grant_found = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  // Only the winner sees rdy
  always_comb begin
    x_w_rdy            = '0;
    x_w_rdy[grant_idx] = grant_found;
  end

  // Pointer moves past the winner
  always_comb begin
    if (grant_idx == pipe_bits'(num_pipes - 1)) begin
      next_ptr = '0;
    end else begin
      next_ptr = grant_idx + 1'b1;
    end
  end

  assign sel_msg = x_w_msg[grant_idx];

  // --------------------------------------------------
  // Control state
  // --------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_ptr       <= '0;
      complete_val <= 1'b0;
    end else begin
      // Strobe only on an accepting edge
      complete_val <= grant_found;
      if (grant_found) begin
        rr_ptr <= next_ptr;
      end
    end
  end

  // --------------------------------------------------
  // Completion payload
  // --------------------------------------------------

  // Held between acceptances, qualified by complete_val
  always_ff @(posedge clk) begin
    if (grant_found) begin
      complete_msg.seq_num <= sel_msg.seq_num;
      complete_msg.waddr   <= sel_msg.waddr;
      complete_msg.wdata   <= sel_msg.wdata;
      complete_msg.wen     <= sel_msg.wen;
      // pc goes to the reorder buffer only
      complete_pc          <= sel_msg.pc;
    end
  end

endmodule

`default_nettype wire

// File: design/reorder_buffer.sv
/*
 * Reorder buffer holding completed results by sequence number.
 * Releases the oldest result once it is present, one per cycle,
 * as a registered commit strobe.
 */
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          complete_val,
  input  wbc_pkg::complete_msg_t        complete_msg,
  input  logic [wbc_pkg::addr_bits-1:0] complete_pc,
  output logic                          commit_val,
  output wbc_pkg::commit_msg_t          commit_msg
);

  import wbc_pkg::*;

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  // Entry payload
  commit_msg_t          rob_data [rob_depth];

  // One valid bit per entry
  logic [rob_depth-1:0] rob_valid;

  // Sequence number of the oldest uncommitted result
  logic [seq_bits-1:0]  head_seq;

  // Entry slots
  logic [rob_idx_bits-1:0] head_idx;
  logic [rob_idx_bits-1:0] wr_idx;

  // Incoming entry, completion fields plus pc
  commit_msg_t          wr_entry;

  // Oldest result has completed
  logic                 head_ready;

  // --------------------------------------------------
  // Indexing
  // --------------------------------------------------

  // Low sequence bits pick the slot
  assign wr_idx   = complete_msg.seq_num[rob_idx_bits-1:0];
  assign head_idx = head_seq[rob_idx_bits-1:0];

  // No bypass, a result written this edge commits next cycle at the earliest
  assign head_ready = rob_valid[head_idx];

  always_comb begin
    wr_entry.pc      = complete_pc;
    wr_entry.seq_num = complete_msg.seq_num;
    wr_entry.waddr   = complete_msg.waddr;
    wr_entry.wdata   = complete_msg.wdata;
    wr_entry.wen     = complete_msg.wen;
  end

  // --------------------------------------------------
  // Entry write
  // --------------------------------------------------

  // Payload only, qualified by the valid bits
  always_ff @(posedge clk) begin
    if (complete_val) begin
      rob_data[wr_idx] <= wr_entry;
    end
  end

  // --------------------------------------------------
  // Valid bits and head
  // --------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rob_valid <= '0;
      head_seq  <= '0;
    end else begin
      // Retire the head
      if (head_ready) begin
        rob_valid[head_idx] <= 1'b0;
        head_seq            <= head_seq + 1'b1;
      end
      // Mark the new arrival
      // Slot differs from the head while in-flight count stays in range
      if (complete_val) begin
        rob_valid[wr_idx] <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Commit outputs
  // --------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      commit_val <= 1'b0;
    end else begin
      // One-cycle strobe per retired entry
      commit_val <= head_ready;
    end
  end

  // Payload held until the next commit
  always_ff @(posedge clk) begin
    if (head_ready) begin
      commit_msg <= rob_data[head_idx];
    end
  end

endmodule

`default_nettype wire

// File: design/arch_reg_file.sv
/*
 * Architectural register file, written by commit notifications.
 * One asynchronous read port; register zero is hardwired to zero.
 */
`timescale 1ns/1ns
`default_nettype none

module arch_reg_file (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              commit_val,
  input  wbc_pkg::commit_msg_t              commit_msg,
  input  logic [wbc_pkg::reg_addr_bits-1:0] rd_addr,
  output logic [wbc_pkg::data_bits-1:0]     rd_data
);

  import wbc_pkg::*;

  // Writable registers, x0 has no storage
  logic [data_bits-1:0] regs [1:num_regs-1];

  // Commit that really writes
  logic                 wr_en;

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------

  assign wr_en = commit_val && commit_msg.wen && (commit_msg.waddr != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[commit_msg.waddr] <= commit_msg.wdata;
    end
  end

  // --------------------------------------------------
  // Read port
  // --------------------------------------------------

  // Combinational, new value visible the cycle after the write
  always_comb begin
    if (rd_addr == '0) begin
      rd_data = '0;
    end else begin
      rd_data = regs[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: design/writeback_commit_top.sv
/*
 * Writeback and in-order commit stage.
 * Execute results enter through the select unit, wait in the reorder
 * buffer, and update the register file at commit.
 */
`timescale 1ns/1ns
`default_nettype none

module writeback_commit_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  wbc_pkg::x_w_msg_t                 x_w_msg [wbc_pkg::num_pipes],
  input  logic [wbc_pkg::num_pipes-1:0]     x_w_val,
  output logic [wbc_pkg::num_pipes-1:0]     x_w_rdy,
  output logic                              complete_val,
  output wbc_pkg::complete_msg_t            complete_msg,
  output logic                              commit_val,
  output wbc_pkg::commit_msg_t              commit_msg,
  input  logic [wbc_pkg::reg_addr_bits-1:0] rd_addr,
  output logic [wbc_pkg::data_bits-1:0]     rd_data
);

  import wbc_pkg::*;

  // pc travels beside the completion broadcast
  logic [addr_bits-1:0] complete_pc;

  // --------------------------------------------------
  // Pipe arbitration and completion
  // --------------------------------------------------

  writeback_select u_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .x_w_msg      (x_w_msg),
    .x_w_val      (x_w_val),
    .x_w_rdy      (x_w_rdy),
    .complete_val (complete_val),
    .complete_msg (complete_msg),
    .complete_pc  (complete_pc)
  );

  // --------------------------------------------------
  // In-order commit
  // --------------------------------------------------

  reorder_buffer u_rob (
    .clk          (clk),
    .rst_n        (rst_n),
    .complete_val (complete_val),
    .complete_msg (complete_msg),
    .complete_pc  (complete_pc),
    .commit_val   (commit_val),
    .commit_msg   (commit_msg)
  );

  // Architectural state
  arch_reg_file u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .commit_val (commit_val),
    .commit_msg (commit_msg),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data)
  );

endmodule

`default_nettype wire

// File: verification/wbc_checker.sv
/*
 * Checker for the writeback and commit stage. Watches the DUT ports,
 * predicts completions from acceptances and commits from the stimulus table.
 */
`timescale 1ns/1ns
`default_nettype none

module wbc_checker #(
  parameter int num_rows = 24
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  wbc_pkg::x_w_msg_t                 x_w_msg [wbc_pkg::num_pipes],
  input  logic [wbc_pkg::num_pipes-1:0]     x_w_val,
  input  logic [wbc_pkg::num_pipes-1:0]     x_w_rdy,
  input  logic                              complete_val,
  input  wbc_pkg::complete_msg_t            complete_msg,
  input  logic                              commit_val,
  input  wbc_pkg::commit_msg_t              commit_msg,
  input  logic [wbc_pkg::reg_addr_bits-1:0] rd_addr,
  input  logic [wbc_pkg::data_bits-1:0]     rd_data,
  input  wbc_pkg::x_w_msg_t                 ref_rows [num_rows],
  input  logic                              rd_zero,
  input  logic                              rd_final,
  output int                                commits_seen,
  output int                                check_count,
  output int                                error_count
);

  import wbc_pkg::*;

  // Completion owed from the previous edge
  logic                pend_val = 1'b0;
  complete_msg_t       pend_msg;
  // Results already broadcast as complete
  logic [num_rows-1:0] completed = '0;
  int                  last_pipe = -1;

  initial begin
    commits_seen = 0;
    check_count  = 0;
    error_count  = 0;
  end

  task automatic report(input string what);
    error_count++;
    $display("Fail at %0t ns: %s", $time, what);
  endtask

  function automatic x_w_msg_t row_for_seq(input int s);
    for (int i = 0; i < num_rows; i++) begin
      if (int'(ref_rows[i].seq_num) == s) begin
        return ref_rows[i];
      end
    end
    return '0;
  endfunction

  // Last write in sequence order wins, x0 stays zero
  function automatic logic [data_bits-1:0] final_reg(input int a);
    logic [data_bits-1:0] val;
    x_w_msg_t             row;
    val = '0;
    for (int s = 0; s < num_rows; s++) begin
      row = row_for_seq(s);
      if (row.wen && int'(row.waddr) == a && a != 0) begin
        val = row.wdata;
      end
    end
    return val;
  endfunction

  always @(posedge clk) begin
    logic [num_pipes-1:0] acc;
    x_w_msg_t             exp_row;
    logic [data_bits-1:0] exp_rd;
    acc = x_w_val & x_w_rdy;

    // Register readback
    if (rd_zero || rd_final) begin
      exp_rd = rd_final ? final_reg(int'(rd_addr)) : '0;
      check_count++;
      if (rd_data !== exp_rd) begin
        report($sformatf("x%0d reads %h, expected %h", rd_addr, rd_data, exp_rd));
      end
    end

    if (!rst_n) begin
      check_count++;
      if (x_w_rdy !== '0 || complete_val !== 1'b0 || commit_val !== 1'b0) begin
        report("x_w_rdy, complete_val or commit_val high during reset");
      end
      pend_val     = 1'b0;
      completed    = '0;
      last_pipe    = -1;
      commits_seen = 0;
    end else begin
      // ------------------------------------------------
      // Grant shape
      // ------------------------------------------------
      check_count++;
      if ((x_w_rdy & (x_w_rdy - 1'b1)) != '0 || (x_w_rdy & ~x_w_val) != '0) begin
        report($sformatf("x_w_rdy %b with x_w_val %b", x_w_rdy, x_w_val));
      end else if (x_w_val != '0 && x_w_rdy == '0) begin
        report($sformatf("no rdy while x_w_val is %b", x_w_val));
      end

      // Completion one cycle after acceptance
      check_count++;
      if (complete_val !== pend_val) begin
        report($sformatf("complete_val %b, expected %b", complete_val, pend_val));
      end else if (pend_val && complete_msg !== pend_msg) begin
        report($sformatf("complete_msg %h, expected %h", complete_msg, pend_msg));
      end

      // ------------------------------------------------
      // In-order commit
      // ------------------------------------------------
      if (commit_val) begin
        check_count++;
        exp_row = row_for_seq(commits_seen);
        if (commits_seen >= num_rows) begin
          report($sformatf("extra commit of seq %0d", commit_msg.seq_num));
        end else if (!completed[commits_seen]) begin
          report($sformatf("seq %0d committed before its completion", commits_seen));
        end else if (commit_msg !== exp_row) begin
          report($sformatf("commit %h, expected %h", commit_msg, exp_row));
        end
        commits_seen++;
      end
      // Marked after the commit check, so same-edge commits count as early
      if (complete_val && int'(complete_msg.seq_num) < num_rows) begin
        completed[complete_msg.seq_num] = 1'b1;
      end

      // Next owed completion
      pend_val = |acc;
      for (int p = 0; p < num_pipes; p++) begin
        if (acc[p]) begin
          if (&x_w_val && p == last_pipe) begin
            report($sformatf("pipe %0d won twice in a row with all pipes valid", p));
          end
          pend_msg.seq_num = x_w_msg[p].seq_num;
          pend_msg.waddr   = x_w_msg[p].waddr;
          pend_msg.wdata   = x_w_msg[p].wdata;
          pend_msg.wen     = x_w_msg[p].wen;
          last_pipe        = p;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/wbc_tb.sv
/*
 * Testbench for the writeback and commit stage.
 * Plays a table of out-of-order results from two pipes, waits for all commits,
 * then sweeps the register file read port. The checker module does the comparing.
 */
`timescale 1ns/1ns
`default_nettype none

module wbc_tb;

  import wbc_pkg::*;

  localparam int num_rows       = 24;
  localparam int clk_period     = 4;
  localparam int reset_cycles   = 16;
  localparam int timeout_cycles = reset_cycles + num_rows * 20 + 64;

  // One table row, issuing pipe plus result
  typedef struct packed {
    logic [pipe_bits-1:0] pipe;
    x_w_msg_t             msg;
  } stim_row_t;

  logic                     clk;
  logic                     rst_n;
  x_w_msg_t                 x_w_msg [num_pipes];
  logic [num_pipes-1:0]     x_w_val;
  logic [num_pipes-1:0]     x_w_rdy;
  logic                     complete_val;
  complete_msg_t            complete_msg;
  logic                     commit_val;
  commit_msg_t              commit_msg;
  logic [reg_addr_bits-1:0] rd_addr;
  logic [data_bits-1:0]     rd_data;

  // Readback modes and checker counters
  logic rd_zero;
  logic rd_final;
  int   commits_seen;
  int   check_count;
  int   error_count;

  // Stimulus table, and the same results for the checker
  stim_row_t rows [num_rows];
  x_w_msg_t  ref_rows [num_rows];
  int        n_rows;
  int        seed;

  // Drive state, cursor into the table per pipe
  int                   cur [num_pipes];
  int                   gap [num_pipes];
  logic [num_pipes-1:0] accepted;
  int                   sent;

  writeback_commit_top dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .x_w_msg      (x_w_msg),
    .x_w_val      (x_w_val),
    .x_w_rdy      (x_w_rdy),
    .complete_val (complete_val),
    .complete_msg (complete_msg),
    .commit_val   (commit_val),
    .commit_msg   (commit_msg),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data)
  );

  wbc_checker #(.num_rows(num_rows)) chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .x_w_msg      (x_w_msg),
    .x_w_val      (x_w_val),
    .x_w_rdy      (x_w_rdy),
    .complete_val (complete_val),
    .complete_msg (complete_msg),
    .commit_val   (commit_val),
    .commit_msg   (commit_msg),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .ref_rows     (ref_rows),
    .rd_zero      (rd_zero),
    .rd_final     (rd_final),
    .commits_seen (commits_seen),
    .check_count  (check_count),
    .error_count  (error_count)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic add_row(input int pipe, input logic [31:0] pc, input logic [7:0] seq,
                         input logic [4:0] waddr, input logic [31:0] wdata, input logic wen);
    rows[n_rows].pipe        = pipe_bits'(pipe);
    rows[n_rows].msg.pc      = pc;
    rows[n_rows].msg.seq_num = seq;
    rows[n_rows].msg.waddr   = waddr;
    rows[n_rows].msg.wdata   = wdata;
    rows[n_rows].msg.wen     = wen;
    ref_rows[n_rows]         = rows[n_rows].msg;
    n_rows++;
  endtask

  // Next table row issued by pipe p, num_rows when none is left
  function automatic int next_row_of(input int p, input int from);
    for (int i = from; i < num_rows; i++) begin
      if (int'(rows[i].pipe) == p) begin
        return i;
      end
    end
    return num_rows;
  endfunction

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b1;
    x_w_val  = '0;
    rd_addr  = '0;
    rd_zero  = 1'b1;
    rd_final = 1'b0;
    accepted = '0;
    sent     = 0;
    n_rows   = 0;
    seed     = 66493;
    for (int p = 0; p < num_pipes; p++) begin
      x_w_msg[p] = '0;
      gap[p]     = 0;
    end
    // pipe, pc, seq, waddr, wdata, wen
    add_row(0, 32'h0000_1004, 8'd1,  5'd2,  32'h7E00_1001, 1'b1);
    add_row(1, 32'h0000_1000, 8'd0,  5'd1,  32'h7E00_1000, 1'b1);
    add_row(0, 32'h0000_100C, 8'd3,  5'd0,  32'h7E00_1003, 1'b1);
    add_row(1, 32'h0000_1008, 8'd2,  5'd1,  32'h7E00_1002, 1'b1);
    add_row(0, 32'h0000_1010, 8'd4,  5'd5,  32'h7E00_1004, 1'b0);
    add_row(1, 32'h0000_1018, 8'd6,  5'd2,  32'h7E00_1006, 1'b1);
    add_row(0, 32'h0000_1014, 8'd5,  5'd3,  32'h7E00_1005, 1'b1);
    add_row(1, 32'h0000_1024, 8'd9,  5'd6,  32'h7E00_1009, 1'b1);
    add_row(0, 32'h0000_101C, 8'd7,  5'd4,  32'h7E00_1007, 1'b1);
    add_row(0, 32'h0000_1020, 8'd8,  5'd3,  32'h7E00_1008, 1'b0);
    add_row(1, 32'h0000_102C, 8'd11, 5'd7,  32'h7E00_1011, 1'b1);
    add_row(1, 32'h0000_1028, 8'd10, 5'd7,  32'h7E00_1010, 1'b1);
    add_row(0, 32'h0000_1034, 8'd13, 5'd9,  32'h7E00_1013, 1'b1);
    add_row(1, 32'h0000_1030, 8'd12, 5'd9,  32'h7E00_1012, 1'b1);
    add_row(0, 32'h0000_103C, 8'd15, 5'd31, 32'h7E00_1015, 1'b1);
    add_row(0, 32'h0000_1038, 8'd14, 5'd31, 32'h7E00_1014, 1'b1);
    add_row(1, 32'h0000_1044, 8'd17, 5'd11, 32'h7E00_1017, 1'b0);
    add_row(0, 32'h0000_1040, 8'd16, 5'd10, 32'h7E00_1016, 1'b1);
    add_row(1, 32'h0000_1050, 8'd20, 5'd12, 32'h7E00_1020, 1'b0);
    add_row(0, 32'h0000_1048, 8'd18, 5'd12, 32'h7E00_1018, 1'b1);
    add_row(1, 32'h0000_104C, 8'd19, 5'd12, 32'h7E00_1019, 1'b1);
    add_row(0, 32'h0000_105C, 8'd23, 5'd1,  32'h7E00_1023, 1'b1);
    add_row(1, 32'h0000_1054, 8'd21, 5'd13, 32'h7E00_1021, 1'b1);
    add_row(0, 32'h0000_1058, 8'd22, 5'd1,  32'h7E00_1022, 1'b1);
    for (int p = 0; p < num_pipes; p++) begin
      cur[p] = next_row_of(p, 0);
    end

    // Reset, reading registers meanwhile
    #1 rst_n = 1'b0;
    for (int i = 0; i < reset_cycles; i++) begin
      @(negedge clk);
      rd_addr = reg_addr_bits'(i);
    end
    rst_n = 1'b1;
    for (int i = 0; i < num_regs; i++) begin
      @(negedge clk);
      rd_addr = reg_addr_bits'(i);
    end
    @(negedge clk);
    rd_zero = 1'b0;

    // ------------------------------------------------
    // Present rows, hold each until accepted
    // ------------------------------------------------
    while (sent < num_rows) begin
      @(negedge clk);
      for (int p = 0; p < num_pipes; p++) begin
        if (accepted[p]) begin
          x_w_val[p] = 1'b0;
          gap[p]     = $unsigned($random(seed)) % 4;
        end
        if (!x_w_val[p] && cur[p] < num_rows) begin
          if (gap[p] > 0) begin
            gap[p]--;
          end else if (int'(rows[cur[p]].msg.seq_num) < commits_seen + rob_depth) begin
            // Keep in-flight results inside the buffer window
            x_w_msg[p] = rows[cur[p]].msg;
            x_w_val[p] = 1'b1;
          end
        end
      end
      @(posedge clk);
      accepted = x_w_val & x_w_rdy;
      for (int p = 0; p < num_pipes; p++) begin
        if (accepted[p]) begin
          sent++;
          cur[p] = next_row_of(p, cur[p] + 1);
        end
      end
    end
    @(negedge clk);
    x_w_val = '0;

    // Drain, then read back every register
    wait (commits_seen == num_rows);
    for (int i = 0; i < num_regs; i++) begin
      @(negedge clk);
      rd_final = 1'b1;
      rd_addr  = reg_addr_bits'(i);
    end
    @(negedge clk);
    rd_final = 1'b0;

    $display("Checks: %0d  errors: %0d  commits: %0d", check_count, error_count, commits_seen);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(timeout_cycles * clk_period);
    $display("Run did not finish within %0d cycles, only %0d of %0d results committed",
             timeout_cycles, commits_seen, num_rows);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: writeback_commit.f
design/wbc_pkg.sv
design/writeback_select.sv
design/reorder_buffer.sv
design/arch_reg_file.sv
design/writeback_commit_top.sv
verification/wbc_checker.sv
verification/wbc_tb.sv
